/* bench/serial_wb_bridge_assertions.sv */
module serial_wb_bridge_assertions (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             cs_ni,
  input  logic             miso_i,
  input  logic             irq_i,
  input  logic             rx_req_i,
  input  logic [7:0]       rx_data_i,
  input  wbs_pkg::wb_req_t bus_req_i,
  input  wbs_pkg::wb_rsp_t bus_rsp_i,
  input  wbs_pkg::wb_rsp_t reg_rsp_i,
  input  wbs_pkg::wb_rsp_t tmr_rsp_i
);

  // Failed assertions so far, watched by the testbench
  int unsigned fail_cnt = 0;

  logic       selected_q;
  logic       pending_q;
  logic [7:0] prev_byte_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      selected_q  <= 1'b0;
      pending_q   <= 1'b0;
      prev_byte_q <= 8'h00;
    end else begin
      if (!cs_ni) begin
        selected_q <= 1'b1;
      end
      if (bus_req_i.stb) begin
        pending_q <= 1'b1;
      end else if (bus_rsp_i.ack) begin
        pending_q <= 1'b0;
      end
      // Last completed byte, the command byte when a write strobe fires
      if (rx_req_i) begin
        prev_byte_q <= rx_data_i;
      end
    end
  end

  // Everything quiet until the host selects the target for the first time
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !selected_q |-> !miso_i && !irq_i && !bus_req_i.stb && !bus_rsp_i.ack
                    && !reg_rsp_i.ack && !tmr_rsp_i.ack)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Bus or pin activity before the first chip select");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.stb |=> !bus_req_i.stb)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Strobe longer than one cycle");
  end

  // No second strobe while an access is open
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.stb |-> !pending_q)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Strobe issued before the previous ack");
  end

  // Exactly one ack per strobe, never in the strobe cycle itself
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_rsp_i.ack || reg_rsp_i.ack || tmr_rsp_i.ack) |-> pending_q)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Ack without an open access");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.stb && bus_req_i.we |-> rx_req_i
      && prev_byte_q[wbs_pkg::CMD_WRITE_BIT]
      && bus_req_i.adr == prev_byte_q[3:0]
      && bus_req_i.dat == rx_data_i)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Write strobe does not match the command and data bytes");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.stb && !bus_req_i.we |-> rx_req_i
      && !rx_data_i[wbs_pkg::CMD_WRITE_BIT]
      && bus_req_i.adr == rx_data_i[3:0])
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Read strobe does not match the command byte");
  end

endmodule

bind serial_wb_bridge serial_wb_bridge_assertions u_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .cs_ni     (cs_ni),
  .miso_i    (miso_o),
  .irq_i     (irq_o),
  .rx_req_i  (rx_req),
  .rx_data_i (rx_data),
  .bus_req_i (bus_req),
  .bus_rsp_i (bus_rsp),
  .reg_rsp_i (reg_rsp),
  .tmr_rsp_i (tmr_rsp)
);

/* bench/tb_serial_wb_bridge.sv */
module tb_serial_wb_bridge;

  localparam int ACK_DELAY      = 3;
  localparam int PRESCALE_W     = 2;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int IRQ_WAIT_LIMIT = 200;

  logic       clk_i;
  logic       rst_ni;
  logic       sclk_i;
  logic       cs_ni;
  logic       mosi_i;
  logic       miso_o;
  logic       irq_o;

  // Expected register bank contents
  logic [7:0] model [8];
  integer     seed;
  int         cycles = 0;

  serial_wb_bridge #(
    .ACK_DELAY  (ACK_DELAY),
    .PRESCALE_W (PRESCALE_W)
  ) dut0 (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .sclk_i (sclk_i),
    .cs_ni  (cs_ni),
    .mosi_i (mosi_i),
    .miso_o (miso_o),
    .irq_o  (irq_o)
  );

  always #2 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      abort_run("Timeout, the test sequence did not finish in time");
    end else if (dut0.u_sva.fail_cnt != 0) begin
      abort_run("A bus protocol assertion failed");
    end
  end

  task automatic abort_run(input string why);
    $display("TB FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_answer(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Error: time %0t, miso byte is %02h, expected %02h", $time, got, exp);
      abort_run("Answer byte on miso_o differs from the expected value");
    end
  endtask

  function automatic logic [3:0] timer_addr(input logic [1:0] offs);
    logic [3:0] adr;
    adr = {2'b00, offs};
    adr[wbs_pkg::TIMER_BASE] = 1'b1;
    return adr;
  endfunction

  // Serial clock high for half a period, then back low
  task automatic clock_edge();
    sclk_i = 1'b1;
    repeat (8) @(negedge clk_i);
    sclk_i = 1'b0;
  endtask

  // Shifts all bits but leaves out the last rising edge, so the caller
  // decides whether the byte completes or the frame is dropped
  task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi_i = tx[i];
      repeat (8) @(negedge clk_i);
      rx[i] = miso_o;
      if (i > 0) begin
        clock_edge();
      end
    end
  endtask

  task automatic open_frame();
    cs_ni = 1'b0;
    repeat (4) @(negedge clk_i);
  endtask

  task automatic close_frame();
    cs_ni  = 1'b1;
    mosi_i = 1'b0;
    repeat (8) @(negedge clk_i);
  endtask

  // Sends filler bytes until the done code shows and leaves that byte open
  task automatic wait_done(output int waits);
    logic [7:0] rx;
    waits = 0;
    shift_byte(8'h00, rx);
    while (rx == wbs_pkg::RESP_WAIT) begin
      waits++;
      clock_edge();
      shift_byte(8'h00, rx);
    end
    check_answer(rx, wbs_pkg::RESP_DONE);
  endtask

  task automatic bus_write(input logic [3:0] adr, input logic [7:0] dat);
    logic [7:0] cmd;
    logic [7:0] rx;
    int         waits;
    cmd = {4'h0, adr};
    cmd[wbs_pkg::CMD_WRITE_BIT] = 1'b1;
    open_frame();
    shift_byte(cmd, rx);
    clock_edge();
    // Answer to the command byte comes back during the data byte
    shift_byte(dat, rx);
    check_answer(rx, wbs_pkg::RESP_WAIT);
    clock_edge();
    wait_done(waits);
    if (waits == 0) begin
      abort_run("Write reported done without a wait answer before it");
    end
    close_frame();
  endtask

  task automatic expect_read(input logic [3:0] adr, input logic [7:0] exp);
    logic [7:0] rx;
    int         waits;
    open_frame();
    shift_byte({4'h0, adr}, rx);
    clock_edge();
    wait_done(waits);
    if (waits == 0) begin
      abort_run("Read reported done without a wait answer before it");
    end
    // Complete the done byte so the data follows on the next filler
    clock_edge();
    shift_byte(8'h00, rx);
    check_answer(rx, exp);
    close_frame();
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (irq_o !== 1'b1 && n < IRQ_WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (irq_o !== 1'b1) begin
      abort_run("irq_o did not rise after the timer reached CMP");
    end
  endtask

  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    sclk_i = 1'b0;
    cs_ni  = 1'b1;
    mosi_i = 1'b0;
    seed   = 32'hb636ca64;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (20) @(negedge clk_i);

    // Bank comes out of reset cleared
    expect_read(4'h5, 8'h00);

    for (int a = 0; a < 8; a++) begin
      model[a] = 8'($random(seed));
      bus_write(4'(a), model[a]);
    end
    for (int a = 7; a >= 0; a--) begin
      expect_read(4'(a), model[a]);
    end

    // Timer with compare at 5
    bus_write(timer_addr(wbs_pkg::TMR_CMP), 8'h05);
    expect_read(timer_addr(wbs_pkg::TMR_CMP), 8'h05);
    bus_write(timer_addr(wbs_pkg::TMR_COUNT), 8'h00);
    if (irq_o !== 1'b0) begin
      abort_run("irq_o high before the timer was enabled");
    end
    bus_write(timer_addr(wbs_pkg::TMR_CTRL), 8'h01);
    wait_irq();
    // Stop counting so the flag is not set again after the clear
    bus_write(timer_addr(wbs_pkg::TMR_CTRL), 8'h00);
    expect_read(timer_addr(wbs_pkg::TMR_STATUS), 8'h01);
    bus_write(timer_addr(wbs_pkg::TMR_STATUS), 8'h01);
    if (irq_o !== 1'b0) begin
      abort_run("irq_o still high after clearing the match flag");
    end
    expect_read(timer_addr(wbs_pkg::TMR_STATUS), 8'h00);

    if (dut0.u_sva.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("A bus protocol assertion failed");
    end
  end

endmodule

/* build.f */
hw/wbs_pkg.sv
hw/serial_byte_link.sv
hw/wb_serial_ctrl.sv
hw/wb_addr_decode.sv
hw/wb_reg_bank.sv
hw/wb_timer.sv
hw/serial_wb_bridge.sv
bench/serial_wb_bridge_assertions.sv
bench/tb_serial_wb_bridge.sv

/* hw/serial_byte_link.sv */
module serial_byte_link (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       sclk_i,
  input  logic       cs_ni,
  input  logic       mosi_i,
  output logic       miso_o,
  output logic [7:0] rx_data_o,
  output logic       rx_req_o,
  input  logic [7:0] tx_data_i
);

  // Two-stage synchronizers, index 1 is the settled value
  logic [1:0] sclk_sync_q;
  logic [1:0] cs_sync_q;
  logic [1:0] mosi_sync_q;
  logic       sclk_prev_q;

  logic       sclk_s;
  logic       cs_s;
  logic       mosi_s;
  logic       sclk_rise;
  logic       sclk_fall;

  logic [2:0] bit_cnt_q;
  logic [6:0] rx_shift_q;
  logic [7:0] rx_data_q;
  logic [7:0] tx_shift_q;
  logic [1:0] done_pipe_q;
  logic       rx_req_q;

  assign sclk_s = sclk_sync_q[1];
  assign cs_s   = cs_sync_q[1];
  assign mosi_s = mosi_sync_q[1];

  // Edges only count while the host has the target selected
  assign sclk_rise = sclk_s & ~sclk_prev_q & ~cs_s;
  assign sclk_fall = ~sclk_s & sclk_prev_q & ~cs_s;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sclk_sync_q <= 2'b00;
      cs_sync_q   <= 2'b11;
      mosi_sync_q <= 2'b00;
      sclk_prev_q <= 1'b0;
    end else begin
      sclk_sync_q <= {sclk_sync_q[0], sclk_i};
      cs_sync_q   <= {cs_sync_q[0], cs_ni};
      mosi_sync_q <= {mosi_sync_q[0], mosi_i};
      sclk_prev_q <= sclk_s;
    end
  end

  // Receive side, MSB first on rising edges
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bit_cnt_q   <= 3'd0;
      done_pipe_q <= 2'b00;
      rx_req_q    <= 1'b0;
    end else begin
      done_pipe_q <= {done_pipe_q[0], sclk_rise && (bit_cnt_q == 3'd7)};
      rx_req_q    <= done_pipe_q[1];
      if (cs_s) begin
        bit_cnt_q <= 3'd0;
      end else if (sclk_rise) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sclk_rise) begin
      rx_shift_q <= {rx_shift_q[5:0], mosi_s};
      if (bit_cnt_q == 3'd7) begin
        rx_data_q <= {rx_shift_q, mosi_s};
      end
    end
  end

  // Transmit side
  // The falling edge that closes a byte (count back at zero) must not shift,
  // otherwise the freshly loaded answer would lose its MSB
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      tx_shift_q <= 8'h00;
    end else if (rx_req_q) begin
      tx_shift_q <= tx_data_i;
    end else if (sclk_fall && (bit_cnt_q != 3'd0)) begin
      tx_shift_q <= {tx_shift_q[6:0], 1'b0};
    end
  end

  assign miso_o    = tx_shift_q[7];
  assign rx_data_o = rx_data_q;
  assign rx_req_o  = rx_req_q;

endmodule

/* hw/serial_wb_bridge.sv */
module serial_wb_bridge #(
  parameter int ACK_DELAY  = 3,
  parameter int PRESCALE_W = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic sclk_i,
  input  logic cs_ni,
  input  logic mosi_i,
  output logic miso_o,
  output logic irq_o
);

  logic [7:0]       rx_data;
  logic             rx_req;
  logic [7:0]       tx_data;
  wbs_pkg::wb_req_t bus_req;
  wbs_pkg::wb_rsp_t bus_rsp;
  wbs_pkg::wb_req_t reg_req;
  wbs_pkg::wb_rsp_t reg_rsp;
  wbs_pkg::wb_req_t tmr_req;
  wbs_pkg::wb_rsp_t tmr_rsp;

  serial_byte_link u_link (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .sclk_i    (sclk_i),
    .cs_ni     (cs_ni),
    .mosi_i    (mosi_i),
    .miso_o    (miso_o),
    .rx_data_o (rx_data),
    .rx_req_o  (rx_req),
    .tx_data_i (tx_data)
  );

  wb_serial_ctrl u_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rx_data_i (rx_data),
    .rx_req_i  (rx_req),
    .tx_data_o (tx_data),
    .wb_req_o  (bus_req),
    .wb_rsp_i  (bus_rsp)
  );

  wb_addr_decode u_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (bus_req),
    .reg_req_o (reg_req),
    .tmr_req_o (tmr_req),
    .reg_rsp_i (reg_rsp),
    .tmr_rsp_i (tmr_rsp),
    .rsp_o     (bus_rsp)
  );

  wb_reg_bank #(
    .ACK_DELAY (ACK_DELAY)
  ) u_reg_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (reg_req),
    .rsp_o  (reg_rsp)
  );

  wb_timer #(
    .PRESCALE_W (PRESCALE_W)
  ) u_timer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (tmr_req),
    .rsp_o  (tmr_rsp),
    .irq_o  (irq_o)
  );

endmodule

/* hw/wb_addr_decode.sv */
module wb_addr_decode (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  wbs_pkg::wb_req_t req_i,
  output wbs_pkg::wb_req_t reg_req_o,
  output wbs_pkg::wb_req_t tmr_req_o,
  input  wbs_pkg::wb_rsp_t reg_rsp_i,
  input  wbs_pkg::wb_rsp_t tmr_rsp_i,
  output wbs_pkg::wb_rsp_t rsp_o
);

  logic             hit_tmr;
  logic             sel_tmr_q;
  logic             pending_q;
  wbs_pkg::wb_rsp_t sel_rsp;

  assign hit_tmr = req_i.adr[wbs_pkg::TIMER_BASE];

  // Both targets see the request, only one sees the strobe
  always_comb begin
    reg_req_o     = req_i;
    tmr_req_o     = req_i;
    reg_req_o.stb = req_i.stb & ~hit_tmr;
    tmr_req_o.stb = req_i.stb & hit_tmr;
  end

  assign sel_rsp = sel_tmr_q ? tmr_rsp_i : reg_rsp_i;

  // Target chosen by the last strobe, open until it answers
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sel_tmr_q <= 1'b0;
      pending_q <= 1'b0;
    end else if (req_i.stb) begin
      sel_tmr_q <= hit_tmr;
      pending_q <= 1'b1;
    end else if (sel_rsp.ack) begin
      pending_q <= 1'b0;
    end
  end

  assign rsp_o.ack = pending_q & sel_rsp.ack;
  assign rsp_o.dat = sel_rsp.dat;

endmodule

/* hw/wb_reg_bank.sv */
module wb_reg_bank #(
  parameter int ACK_DELAY = 0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  wbs_pkg::wb_req_t req_i,
  output wbs_pkg::wb_rsp_t rsp_o
);

  logic [7:0] regs_q [8];
  logic       pending_q;
  logic [2:0] delay_q;
  logic       we_q;
  logic [2:0] adr_q;
  logic [7:0] dat_q;
  logic       done;

  // Access completes once the wait states have run out
  assign done = pending_q && (delay_q == 3'd0);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      delay_q   <= 3'd0;
    end else if (req_i.stb) begin
      pending_q <= 1'b1;
      delay_q   <= 3'(ACK_DELAY);
    end else if (done) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      delay_q <= delay_q - 3'd1;
    end
  end

  // Latched request
  always_ff @(posedge clk_i) begin
    if (req_i.stb) begin
      we_q  <= req_i.we;
      adr_q <= req_i.adr[2:0];
      dat_q <= req_i.dat;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < 8; i++) begin
        regs_q[i] <= 8'h00;
      end
    end else if (done && we_q) begin
      regs_q[adr_q] <= dat_q;
    end
  end

  assign rsp_o.ack = done;
  assign rsp_o.dat = regs_q[adr_q];

endmodule

/* hw/wb_serial_ctrl.sv */
module wb_serial_ctrl (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [7:0]       rx_data_i,
  input  logic             rx_req_i,
  output logic [7:0]       tx_data_o,
  output wbs_pkg::wb_req_t wb_req_o,
  input  wbs_pkg::wb_rsp_t wb_rsp_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE_GET_DATA,
    ST_READ_WAIT_ACK,
    ST_WRITE_WAIT_ACK,
    ST_READ_PUT_DATA
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic       we_q;
  logic       we_d;
  logic [3:0] adr_q;
  logic [3:0] adr_d;
  logic       ack_q;
  logic       ack_d;
  logic [7:0] rdata_q;
  logic [7:0] rdata_d;
  logic       ack_seen;
  logic       stb;
  logic [7:0] wdata;

  // An ack landing in the same cycle as a filler byte already counts
  assign ack_seen = ack_q | wb_rsp_i.ack;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      we_q    <= 1'b0;
      adr_q   <= 4'h0;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      we_q    <= we_d;
      adr_q   <= adr_d;
      ack_q   <= ack_d;
    end
  end

  // Read data is payload and only moves with an ack
  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  always_comb begin
    state_d   = state_q;
    we_d      = we_q;
    adr_d     = adr_q;
    ack_d     = ack_q;
    rdata_d   = rdata_q;
    stb       = 1'b0;
    wdata     = 8'h00;
    tx_data_o = wbs_pkg::RESP_WAIT;

    if (rx_req_i) begin
      case (state_q)
        ST_IDLE: begin
          adr_d = rx_data_i[3:0];
          ack_d = 1'b0;
          if (rx_data_i[wbs_pkg::CMD_WRITE_BIT]) begin
            we_d    = 1'b1;
            state_d = ST_WRITE_GET_DATA;
          end else begin
            // Reads go out right away with the command byte
            we_d    = 1'b0;
            stb     = 1'b1;
            state_d = ST_READ_WAIT_ACK;
          end
        end

        ST_WRITE_GET_DATA: begin
          wdata   = rx_data_i;
          stb     = 1'b1;
          ack_d   = 1'b0;
          state_d = ST_WRITE_WAIT_ACK;
        end

        ST_READ_WAIT_ACK: begin
          if (ack_seen) begin
            tx_data_o = wbs_pkg::RESP_DONE;
            state_d   = ST_READ_PUT_DATA;
          end
        end

        ST_READ_PUT_DATA: begin
          tx_data_o = rdata_q;
          state_d   = ST_IDLE;
        end

        ST_WRITE_WAIT_ACK: begin
          if (ack_seen) begin
            tx_data_o = wbs_pkg::RESP_DONE;
            state_d   = ST_IDLE;
          end
        end

        default: begin
          state_d = ST_IDLE;
        end
      endcase
    end

    // Keep the ack and its data until a filler byte reports them
    if (wb_rsp_i.ack) begin
      ack_d   = 1'b1;
      rdata_d = wb_rsp_i.dat;
    end
  end

  // Strobe and write data are combinational from the received byte
  assign wb_req_o.stb = stb;
  assign wb_req_o.we  = we_d;
  assign wb_req_o.adr = adr_d;
  assign wb_req_o.dat = wdata;

endmodule

/* hw/wb_timer.sv */
module wb_timer #(
  parameter int PRESCALE_W = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  wbs_pkg::wb_req_t req_i,
  output wbs_pkg::wb_rsp_t rsp_o,
  output logic             irq_o
);

  logic                  en_q;
  logic [PRESCALE_W-1:0] presc_q;
  logic [7:0]            count_q;
  logic [7:0]            cmp_q;
  logic                  match_q;
  logic                  ack_q;
  logic [7:0]            rdata_q;
  logic                  tick;
  logic [7:0]            count_next;
  logic                  wr;
  logic [1:0]            offs;

  assign offs       = req_i.adr[1:0];
  assign wr         = req_i.stb & req_i.we;
  assign tick       = en_q && (presc_q == {PRESCALE_W{1'b1}});
  assign count_next = count_q + 8'd1;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      en_q    <= 1'b0;
      presc_q <= '0;
      count_q <= 8'h00;
      cmp_q   <= 8'h00;
      match_q <= 1'b0;
    end else begin
      if (en_q) begin
        presc_q <= presc_q + 1'b1;
      end
      // A host write to COUNT wins over the increment
      if (wr && offs == wbs_pkg::TMR_COUNT) begin
        count_q <= req_i.dat;
      end else if (tick) begin
        count_q <= count_next;
      end
      if (wr && offs == wbs_pkg::TMR_CTRL) begin
        en_q <= req_i.dat[0];
      end
      if (wr && offs == wbs_pkg::TMR_CMP) begin
        cmp_q <= req_i.dat;
      end
      // Flag is set on the step that reaches CMP, so a clear holds
      if (tick && count_next == cmp_q) begin
        match_q <= 1'b1;
      end else if (wr && offs == wbs_pkg::TMR_STATUS && req_i.dat[0]) begin
        match_q <= 1'b0;
      end
    end
  end

  // Single wait state, read data sampled with the strobe
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i.stb;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.stb) begin
      case (offs)
        wbs_pkg::TMR_CTRL:   rdata_q <= {7'd0, en_q};
        wbs_pkg::TMR_COUNT:  rdata_q <= count_q;
        wbs_pkg::TMR_CMP:    rdata_q <= cmp_q;
        default:             rdata_q <= {7'd0, match_q};
      endcase
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rdata_q;
  assign irq_o     = match_q;

endmodule

/* hw/wbs_pkg.sv */
package wbs_pkg;

  // Controller to peripheral request, stb is a one-cycle pulse
  typedef struct packed {
    logic       stb;
    logic       we;
    logic [3:0] adr;
    logic [7:0] dat;
  } wb_req_t;

  // Peripheral to controller response, dat valid with ack on reads
  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

  // Command byte layout
  localparam int CMD_WRITE_BIT = 7;

  // Answer codes sent back on filler bytes
  localparam logic [7:0] RESP_WAIT = 8'h00;
  localparam logic [7:0] RESP_DONE = 8'h01;

  // Address bit that selects the timer over the register bank
  localparam int TIMER_BASE = 3;

  // Timer register offsets
  localparam logic [1:0] TMR_CTRL   = 2'd0;
  localparam logic [1:0] TMR_COUNT  = 2'd1;
  localparam logic [1:0] TMR_CMP    = 2'd2;
  localparam logic [1:0] TMR_STATUS = 2'd3;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  --top-module tb_serial_wb_bridge \
  -f build.f \
  -o sim_serial_wb_bridge
# Let the testbench see assertion failures and end the run itself
./obj_dir/sim_serial_wb_bridge +verilator+error+limit+10
